// ==== Bender.yml ====
package:
  name: rapid_execute

sources:
  # RTL in compile order, package first
  - rtl/rapid_pkg.sv
  - rtl/ex_control_fsm.sv
  - rtl/ex_shift_counter.sv
  - rtl/ex_serial_shifter.sv
  - rtl/ex_alu.sv
  - rtl/ex_branch_unit.sv
  - rtl/execute_stage.sv

  # Testbench, top module execute_stage_tb
  - target: test
    include_dirs:
      - bench
    files:
      - bench/execute_stage_tb.sv

// ==== bench/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Expected behavior of the execute stage
////////////////////////////////////////////////////////////

// Branch condition on the two register operands
function automatic logic branch_taken(input ex_op_e op, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
    case (op)
        OP_BEQ:  return a == b;
        OP_BNE:  return a != b;
        OP_BLT:  return $signed(a) < $signed(b);
        OP_BGE:  return !($signed(a) < $signed(b));
        OP_BLTU: return a < b;
        OP_BGEU: return !(a < b);
        default: return 1'b0;
    endcase
endfunction

// Result, pc load flag and target for one instruction
function automatic void ex_ref_function(
    input  ex_op_e          op,
    input  logic            use_imm,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] result,
    output logic            pc_load,
    output logic [XLEN-1:0] target
);
    logic [XLEN-1:0]    b;
    logic [SHAMT_W-1:0] shamt;
    b      = use_imm ? imm : rs2;
    shamt  = b[SHAMT_W-1:0];
    // Defaults cover plain ops and untaken branches
    result  = '0;
    pc_load = branch_taken(op, rs1, rs2);
    target  = pc_load ? pc + imm : pc + 32'd4;
    case (op)
        OP_ADD:     result = rs1 + b;
        OP_SUB:     result = rs1 - b;
        OP_SLT:     result = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU:    result = (rs1 < b) ? 32'd1 : 32'd0;
        OP_XOR:     result = rs1 ^ b;
        OP_OR:      result = rs1 | b;
        OP_AND:     result = rs1 & b;
        OP_SLL:     result = rs1 << shamt;
        OP_SRL:     result = rs1 >> shamt;
        OP_SRA:     result = $signed(rs1) >>> shamt;
        OP_LUI:     result = imm;
        OP_AUIPC:   result = pc + imm;
        OP_MEMADDR: result = rs1 + imm;
        OP_JAL: begin
            result  = pc + 32'd4;
            pc_load = 1'b1;
            target  = pc + imm;
        end
        OP_JALR: begin
            result  = pc + 32'd4;
            pc_load = 1'b1;
            target  = (rs1 + imm) & ~32'd1;
        end
        default: result = '0;
    endcase
endfunction

// Edges from the accepting handshake to o_valid
// Shifts add one edge per bit
function automatic int ref_latency(input ex_op_e op, input logic [SHAMT_W-1:0] shamt);
    if (op == OP_SLL || op == OP_SRL || op == OP_SRA) begin
        return int'(shamt) + 1;
    end
    return 1;
endfunction

`endif

// ==== bench/execute_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb;
    import rapid_pkg::*;

    `include "ex_ref_model.svh"

    // Instruction counts per test group
    localparam int N_ALU    = 7 * 8 + 3 * 4;
    localparam int N_SHIFT  = 3 * 32;
    localparam int N_BRANCH = 6 * 5;
    localparam int N_JUMP   = 2 * 4;
    localparam int N_STALL  = 40;
    localparam int N_INSTR  = N_ALU + N_SHIFT + N_BRANCH + N_JUMP + N_STALL;
    localparam int N_OPS    = 21;
    localparam int RESET_CYCLES  = 16;
    localparam int TIMEOUT_EDGES = 40 * N_INSTR + RESET_CYCLES;

    logic            i_clk = 1'b0;
    logic            i_reset;
    logic            i_valid;
    logic            o_ready;
    ex_op_e          i_op;
    logic            i_use_imm;
    logic [XLEN-1:0] i_pc;
    logic [XLEN-1:0] i_rs1;
    logic [XLEN-1:0] i_rs2;
    logic [XLEN-1:0] i_imm;
    logic            o_valid;
    logic            i_ready;
    logic [XLEN-1:0] o_result;
    logic            o_pc_load;
    logic [XLEN-1:0] o_pc_target;

    // Expected results in issue order
    logic [XLEN-1:0] exp_result_q[$];
    logic            exp_load_q[$];
    logic [XLEN-1:0] exp_target_q[$];
    int              exp_lat_q[$];
    string           name_q[$];
    int              accept_q[$];

    int              edge_count = 0;
    int              errors = 0;
    int              checks = 0;
    int              issued = 0;
    int              consumed = 0;
    logic            stall_mode = 1'b0;
    // Set when the next o_valid belongs to a new result
    logic            fresh = 1'b1;
    string           cur_name;
    logic [XLEN-1:0] snap_result;
    logic            snap_load;
    logic [XLEN-1:0] snap_target;

    execute_stage dut0 (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .i_op        (i_op),
        .i_use_imm   (i_use_imm),
        .i_pc        (i_pc),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_imm       (i_imm),
        .o_valid     (o_valid),
        .i_ready     (i_ready),
        .o_result    (o_result),
        .o_pc_load   (o_pc_load),
        .o_pc_target (o_pc_target)
    );

    // 4 ns clock
    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        edge_count <= edge_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string test, input string field,
                               input logic [XLEN-1:0] exp, input logic [XLEN-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected 0x%08h actual 0x%08h", test, field, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Word aligned pc
    function automatic logic [XLEN-1:0] rand_pc();
        return $urandom() & 32'hFFFF_FFFC;
    endfunction

    // Sign-extended 12-bit immediate
    function automatic logic [XLEN-1:0] rand_imm12();
        logic [XLEN-1:0] r;
        r = $urandom();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Even branch offset, sign-extended from 13 bits
    function automatic logic [XLEN-1:0] rand_offset();
        logic [XLEN-1:0] r;
        r = $urandom();
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    // Queue the expected outcome, then hold the instruction until accepted
    task automatic issue(input ex_op_e op, input logic use_imm, input logic [XLEN-1:0] pc,
                         input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                         input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] e_result;
        logic            e_load;
        logic [XLEN-1:0] e_target;
        logic [XLEN-1:0] b;
        ex_ref_function(op, use_imm, pc, rs1, rs2, imm, e_result, e_load, e_target);
        b = use_imm ? imm : rs2;
        exp_result_q.push_back(e_result);
        exp_load_q.push_back(e_load);
        exp_target_q.push_back(e_target);
        exp_lat_q.push_back(ref_latency(op, b[SHAMT_W-1:0]));
        name_q.push_back($sformatf("%s#%0d", op.name(), issued));
        i_valid   = 1'b1;
        i_op      = op;
        i_use_imm = use_imm;
        i_pc      = pc;
        i_rs1     = rs1;
        i_rs2     = rs2;
        i_imm     = imm;
        @(negedge i_clk);
        while (!o_ready) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
        i_valid = 1'b0;
        issued++;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            use_imm;
        logic [XLEN-1:0] br_a[5];
        logic [XLEN-1:0] br_b[5];
        void'($urandom(83));
        i_reset   = 1'b1;
        i_valid   = 1'b0;
        i_op      = OP_ADD;
        i_use_imm = 1'b0;
        i_pc      = '0;
        i_rs1     = '0;
        i_rs2     = '0;
        i_imm     = '0;
        i_ready   = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        @(negedge i_clk);
        check_value("reset", "o_valid", 32'(1'b0), 32'(o_valid));
        check_value("reset", "o_ready", 32'(1'b1), 32'(o_ready));
        check_value("reset", "o_pc_load", 32'(1'b0), 32'(o_pc_load));
        check_value("reset", "o_result", '0, o_result);
        @(posedge i_clk);
        #1;
        // ADD through AND, register then immediate form
        for (int k = 0; k < 7; k++) begin
            for (int rep = 0; rep < 8; rep++) begin
                issue(ex_op_e'(k), (rep % 2) == 1, rand_pc(), $urandom(), $urandom(),
                      rand_imm12());
            end
        end
        for (int rep = 0; rep < 4; rep++) begin
            issue(OP_LUI, 1'b1, rand_pc(), $urandom(), $urandom(), $urandom() & 32'hFFFF_F000);
            issue(OP_AUIPC, 1'b1, rand_pc(), $urandom(), $urandom(), $urandom() & 32'hFFFF_F000);
            issue(OP_MEMADDR, 1'b1, rand_pc(), $urandom(), $urandom(), rand_imm12());
        end
        // Every amount for every shift, random upper bits around the shamt
        for (int s = 0; s < 32; s++) begin
            for (int k = 0; k < 3; k++) begin
                a = $urandom();
                a[XLEN-1] = (s % 2) == 1;
                b = ($urandom() & 32'hFFFF_FFE0) | s;
                use_imm = (s % 4) >= 2;
                if (use_imm) begin
                    issue(ex_op_e'(OP_SLL + k), 1'b1, rand_pc(), a, $urandom(), b);
                end else begin
                    issue(ex_op_e'(OP_SLL + k), 1'b0, rand_pc(), a, b, $urandom());
                end
            end
        end
        // Equal, less, greater, and pairs where signed and unsigned order differ
        br_a[0] = 32'd77;
        br_b[0] = 32'd77;
        br_a[1] = 32'd3;
        br_b[1] = 32'd900;
        br_a[2] = 32'd900;
        br_b[2] = 32'd3;
        br_a[3] = 32'hFFFF_FFF0;
        br_b[3] = 32'd5;
        br_a[4] = 32'd5;
        br_b[4] = 32'h8000_0000;
        for (int k = 0; k < 6; k++) begin
            for (int c = 0; c < 5; c++) begin
                issue(ex_op_e'(OP_BEQ + k), (c % 2) == 1, rand_pc(), br_a[c], br_b[c],
                      rand_offset());
            end
        end
        for (int rep = 0; rep < 4; rep++) begin
            issue(OP_JAL, 1'b1, rand_pc(), $urandom(), $urandom(), rand_offset());
            // Odd rs1 plus even imm gives an odd sum, so bit 0 must be cleared
            issue(OP_JALR, 1'b1, rand_pc(), $urandom() | 32'd1, $urandom(),
                  rand_imm12() & ~32'd1);
        end
        // Random mix under downstream back-pressure and upstream gaps
        stall_mode = 1'b1;
        for (int rep = 0; rep < N_STALL; rep++) begin
            issue(ex_op_e'($urandom() % N_OPS), ($urandom() % 2) == 1, rand_pc(), $urandom(),
                  $urandom(), rand_imm12());
            repeat ($urandom() % 3) begin
                @(posedge i_clk);
                #1;
            end
        end
        while (name_q.size() != 0) begin
            @(negedge i_clk);
        end
        // A few idle cycles to catch a duplicated result
        repeat (8) @(negedge i_clk);
        check_value("end of run", "consumed", N_INSTR, consumed);
        finish_run();
    end

    // Random downstream back-pressure
    always @(posedge i_clk) begin
        #1;
        if (stall_mode) begin
            i_ready = ($urandom() % 3) != 0;
        end else begin
            i_ready = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare at the falling edge, where all handshake signals are settled
    ////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (i_valid && o_ready) begin
                accept_q.push_back(edge_count);
            end
            if (o_valid && fresh) begin
                // New result, check its latency and keep a copy
                if (name_q.size() == 0 || accept_q.size() == 0) begin
                    errors++;
                    $display("Result appeared with no instruction outstanding");
                end else begin
                    cur_name = name_q[0];
                    check_value(cur_name, "latency", exp_lat_q.pop_front(),
                                edge_count - accept_q.pop_front());
                end
                snap_result = o_result;
                snap_load   = o_pc_load;
                snap_target = o_pc_target;
                fresh = 1'b0;
            end else if (o_valid) begin
                // Stalled, outputs must not move
                check_value(cur_name, "stalled o_result", snap_result, o_result);
                check_value(cur_name, "stalled o_pc_load", 32'(snap_load), 32'(o_pc_load));
                check_value(cur_name, "stalled o_pc_target", snap_target, o_pc_target);
            end else if (!fresh) begin
                errors++;
                $display("o_valid dropped before %s was taken downstream", cur_name);
                fresh = 1'b1;
            end
            if (o_valid && i_ready) begin
                if (name_q.size() != 0) begin
                    cur_name = name_q.pop_front();
                    check_value(cur_name, "o_result", exp_result_q.pop_front(), o_result);
                    check_value(cur_name, "o_pc_load", 32'(exp_load_q.pop_front()),
                                32'(o_pc_load));
                    check_value(cur_name, "o_pc_target", exp_target_q.pop_front(), o_pc_target);
                end
                consumed++;
                fresh = 1'b1;
            end
        end
    end

    // Run limit from the instruction count
    initial begin
        while (edge_count < TIMEOUT_EDGES) begin
            @(negedge i_clk);
        end
        errors++;
        $display("Timeout: run did not complete within %0d clock cycles", TIMEOUT_EDGES);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== rapid_execute.f ====
+incdir+bench
rtl/rapid_pkg.sv
rtl/ex_control_fsm.sv
rtl/ex_shift_counter.sv
rtl/ex_serial_shifter.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/execute_stage.sv
bench/execute_stage_tb.sv

// ==== rtl/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_load,
    input  rapid_pkg::ex_op_e          i_op,
    input  logic                       i_use_imm,
    input  logic [rapid_pkg::XLEN-1:0] i_pc,
    input  logic [rapid_pkg::XLEN-1:0] i_rs1,
    input  logic [rapid_pkg::XLEN-1:0] i_rs2,
    input  logic [rapid_pkg::XLEN-1:0] i_imm,
    input  logic                       i_sel_shift,
    input  logic [rapid_pkg::XLEN-1:0] i_shift_value,
    input  logic [rapid_pkg::XLEN-1:0] i_link_value,
    output logic [rapid_pkg::XLEN-1:0] o_operand2,
    output logic [rapid_pkg::XLEN-1:0] o_result
);
    import rapid_pkg::*;

    logic [XLEN-1:0] operand2;
    logic [XLEN-1:0] result_d;
    logic [XLEN-1:0] result_q;
    logic            lt_signed;
    logic            lt_unsigned;

    // Immediate or register second operand, shared with the shifter path
    assign operand2   = i_use_imm ? i_imm : i_rs2;
    assign o_operand2 = operand2;

    // Set-less-than compares
    assign lt_signed   = $signed(i_rs1) < $signed(operand2);
    assign lt_unsigned = i_rs1 < operand2;

    ////////////////////////////////////////////////////////////
    // Single-cycle result
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (i_op)
            OP_ADD:     result_d = i_rs1 + operand2;
            OP_SUB:     result_d = i_rs1 - operand2;
            OP_SLT:     result_d = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU:    result_d = {{(XLEN-1){1'b0}}, lt_unsigned};
            OP_XOR:     result_d = i_rs1 ^ operand2;
            OP_OR:      result_d = i_rs1 | operand2;
            OP_AND:     result_d = i_rs1 & operand2;
            // Immediate already sits in the upper 20 bits
            OP_LUI:     result_d = i_imm;
            OP_AUIPC:   result_d = i_pc + i_imm;
            // Jumps write the return address
            OP_JAL:     result_d = i_link_value;
            OP_JALR:    result_d = i_link_value;
            OP_MEMADDR: result_d = i_rs1 + i_imm;
            // Branches write nothing and shifts come from the shifter
            default:    result_d = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            result_q <= '0;
        end else if (i_load) begin
            result_q <= result_d;
        end
    end

    // Shift result bypasses the register
    assign o_result = i_sel_shift ? i_shift_value : result_q;

endmodule

`default_nettype wire

// ==== rtl/ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_load,
    input  rapid_pkg::ex_op_e          i_op,
    input  logic [rapid_pkg::XLEN-1:0] i_pc,
    input  logic [rapid_pkg::XLEN-1:0] i_rs1,
    input  logic [rapid_pkg::XLEN-1:0] i_rs2,
    input  logic [rapid_pkg::XLEN-1:0] i_imm,
    output logic [rapid_pkg::XLEN-1:0] o_link_value,
    output logic                       o_pc_load,
    output logic [rapid_pkg::XLEN-1:0] o_pc_target
);
    import rapid_pkg::*;

    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] jalr_sum;
    logic            taken_d;
    logic [XLEN-1:0] target_d;

    // Fall-through pc doubles as the link value
    assign pc_next      = i_pc + PC_STEP;
    assign o_link_value = pc_next;
    assign pc_rel       = i_pc + i_imm;
    assign jalr_sum     = i_rs1 + i_imm;

    always_comb begin
        taken_d  = 1'b0;
        target_d = pc_next;
        case (i_op)
            OP_BEQ:  taken_d = (i_rs1 == i_rs2);
            OP_BNE:  taken_d = (i_rs1 != i_rs2);
            OP_BLT:  taken_d = ($signed(i_rs1) < $signed(i_rs2));
            OP_BGE:  taken_d = ($signed(i_rs1) >= $signed(i_rs2));
            OP_BLTU: taken_d = (i_rs1 < i_rs2);
            OP_BGEU: taken_d = (i_rs1 >= i_rs2);
            OP_JAL:  taken_d = 1'b1;
            OP_JALR: taken_d = 1'b1;
            default: taken_d = 1'b0;
        endcase
        // JALR target is word-independent with bit 0 forced low
        if (i_op == OP_JALR) begin
            target_d = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (taken_d) begin
            target_d = pc_rel;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_pc_load   <= 1'b0;
            o_pc_target <= '0;
        end else if (i_load) begin
            o_pc_load   <= taken_d;
            o_pc_target <= target_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ex_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_control_fsm (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  rapid_pkg::ex_op_e i_op,
    input  logic              i_ready,
    input  logic              i_count_zero,
    output logic              o_ready,
    output logic              o_valid,
    output logic              o_accept,
    output logic              o_shift_en,
    output logic              o_sel_shift
);
    import rapid_pkg::*;

    ex_state_e state_q;
    ex_state_e state_d;
    logic      is_shift;

    // Shifts take the multi-cycle path
    assign is_shift = (i_op == OP_SLL) || (i_op == OP_SRL) || (i_op == OP_SRA);

    // Shift result is presented as soon as the count runs out
    assign o_valid    = (state_q == ST_DONE) || ((state_q == ST_SHIFT) && i_count_zero);
    // Take new work when empty or when the held result leaves this cycle
    assign o_ready    = (state_q == ST_IDLE) || (o_valid && i_ready);
    assign o_accept   = i_valid && o_ready;
    // One bit per cycle until the counter runs out
    assign o_shift_en = (state_q == ST_SHIFT) && !i_count_zero;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (o_accept) begin
                    state_d = is_shift ? ST_SHIFT : ST_DONE;
                end
            end
            ST_SHIFT, ST_DONE: begin
                // Back-to-back accept when the result drains
                if (o_accept) begin
                    state_d = is_shift ? ST_SHIFT : ST_DONE;
                end else if (o_valid && i_ready) begin
                    state_d = ST_IDLE;
                end else if (o_valid) begin
                    // Stalled result waits in done
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state_q     <= ST_IDLE;
            o_sel_shift <= 1'b0;
        end else begin
            state_q <= state_d;
            // Result source follows the op of the accepted instruction
            if (o_accept) begin
                o_sel_shift <= is_shift;
            end
        end
    end

    // A stalled result parks in done and keeps its result source
    a_stall_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_valid && !i_ready) |=> (state_q == ST_DONE) && o_valid
            && $stable(o_sel_shift)
    );

endmodule

`default_nettype wire

// ==== rtl/ex_serial_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_serial_shifter (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_load,
    input  rapid_pkg::ex_op_e          i_op,
    input  logic [rapid_pkg::XLEN-1:0] i_operand,
    input  logic                       i_shift_en,
    output logic [rapid_pkg::XLEN-1:0] o_value
);
    import rapid_pkg::*;

    logic [XLEN-1:0] value_q;
    // Direction and fill captured with the operand
    logic            left_q;
    logic            arith_q;
    logic            fill_bit;

    // Sign fill only for SRA
    assign fill_bit = arith_q & value_q[XLEN-1];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            left_q  <= 1'b0;
            arith_q <= 1'b0;
        end else if (i_load) begin
            left_q  <= (i_op == OP_SLL);
            arith_q <= (i_op == OP_SRA);
        end
    end

    // One bit per enabled cycle
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            value_q <= i_operand;
        end else if (i_shift_en) begin
            if (left_q) begin
                value_q <= {value_q[XLEN-2:0], 1'b0};
            end else begin
                value_q <= {fill_bit, value_q[XLEN-1:1]};
            end
        end
    end

    assign o_value = value_q;

endmodule

`default_nettype wire

// ==== rtl/ex_shift_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_shift_counter (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_load,
    input  logic [rapid_pkg::SHAMT_W-1:0] i_shamt,
    input  logic                          i_dec,
    output logic                          o_zero
);
    import rapid_pkg::*;

    // Remaining shift steps
    logic [SHAMT_W-1:0] count_q;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            count_q <= '0;
        end else if (i_load) begin
            count_q <= i_shamt;
        end else if (i_dec) begin
            count_q <= count_q - SHAMT_W'(1);
        end
    end

    // Zero ends the shift phase in the FSM
    assign o_zero = (count_q == '0);

    // FSM must stop stepping once the count is exhausted
    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_dec |-> !o_zero
    );

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                       i_clk,
    input  logic                       i_reset,
    // Upstream instruction port
    input  logic                       i_valid,
    output logic                       o_ready,
    input  rapid_pkg::ex_op_e          i_op,
    input  logic                       i_use_imm,
    input  logic [rapid_pkg::XLEN-1:0] i_pc,
    input  logic [rapid_pkg::XLEN-1:0] i_rs1,
    input  logic [rapid_pkg::XLEN-1:0] i_rs2,
    input  logic [rapid_pkg::XLEN-1:0] i_imm,
    // Downstream result port
    output logic                       o_valid,
    input  logic                       i_ready,
    output logic [rapid_pkg::XLEN-1:0] o_result,
    output logic                       o_pc_load,
    output logic [rapid_pkg::XLEN-1:0] o_pc_target
);
    import rapid_pkg::*;

    ////////////////////////////////////////////////////////////
    // Internal control and data
    ////////////////////////////////////////////////////////////

    logic            accept;
    logic            shift_en;
    logic            sel_shift;
    logic            count_zero;
    logic [XLEN-1:0] operand2;
    logic [XLEN-1:0] shift_value;
    logic [XLEN-1:0] link_value;

    // Handshakes and sequencing
    ex_control_fsm u_fsm (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_ready      (i_ready),
        .i_count_zero (count_zero),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_accept     (accept),
        .o_shift_en   (shift_en),
        .o_sel_shift  (sel_shift)
    );

    // Shift amount from the low bits of the second operand
    ex_shift_counter u_counter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (accept),
        .i_shamt (operand2[SHAMT_W-1:0]),
        .i_dec   (shift_en),
        .o_zero  (count_zero)
    );

    ex_serial_shifter u_shifter (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_load     (accept),
        .i_op       (i_op),
        .i_operand  (i_rs1),
        .i_shift_en (shift_en),
        .o_value    (shift_value)
    );

    ex_alu u_alu (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_load        (accept),
        .i_op          (i_op),
        .i_use_imm     (i_use_imm),
        .i_pc          (i_pc),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_imm         (i_imm),
        .i_sel_shift   (sel_shift),
        .i_shift_value (shift_value),
        .i_link_value  (link_value),
        .o_operand2    (operand2),
        .o_result      (o_result)
    );

    // Branch compares always use rs2, never the immediate
    ex_branch_unit u_branch (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_load       (accept),
        .i_op         (i_op),
        .i_pc         (i_pc),
        .i_rs1        (i_rs1),
        .i_rs2        (i_rs2),
        .i_imm        (i_imm),
        .o_link_value (link_value),
        .o_pc_load    (o_pc_load),
        .o_pc_target  (o_pc_target)
    );

endmodule

`default_nettype wire

// ==== rtl/rapid_pkg.sv ====
`default_nettype none

package rapid_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Data and address width of the RV32I core
    localparam int XLEN = 32;

    // Shift amount field, low bits of the second operand
    localparam int SHAMT_W = 5;

    // Encoding widths of the enums below
    localparam int OP_W    = 5;
    localparam int STATE_W = 2;

    // Sequential pc increment, also the link offset for jumps
    localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);

    ////////////////////////////////////////////////////////////
    // Operation
    ////////////////////////////////////////////////////////////

    // One code per decoded instruction class
    // Register and immediate forms share a code and differ by use_imm
    typedef enum logic [OP_W-1:0] {
        // Arithmetic and logic
        OP_ADD     = 5'd0,
        OP_SUB     = 5'd1,
        OP_SLT     = 5'd2,
        OP_SLTU    = 5'd3,
        OP_XOR     = 5'd4,
        OP_OR      = 5'd5,
        OP_AND     = 5'd6,
        // Shifts go through the serial shifter
        OP_SLL     = 5'd7,
        OP_SRL     = 5'd8,
        OP_SRA     = 5'd9,
        // Upper immediates
        OP_LUI     = 5'd10,
        OP_AUIPC   = 5'd11,
        // Unconditional jumps
        OP_JAL     = 5'd12,
        OP_JALR    = 5'd13,
        // Conditional branches
        OP_BEQ     = 5'd14,
        OP_BNE     = 5'd15,
        OP_BLT     = 5'd16,
        OP_BGE     = 5'd17,
        OP_BLTU    = 5'd18,
        OP_BGEU    = 5'd19,
        // Loads and stores, effective address only
        OP_MEMADDR = 5'd20
    } ex_op_e;

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    // Idle waits for work, shift runs the serial shifter,
    // done presents the result downstream
    typedef enum logic [STATE_W-1:0] {
        ST_IDLE  = 2'd0,
        ST_SHIFT = 2'd1,
        ST_DONE  = 2'd2
    } ex_state_e;

endpackage

`default_nettype wire
